// File: design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// cache geometry
`define MEM_CACHE_SETS   16
`define MEM_LINE_BITS    256

// burst side of the memory port
`define MEM_BURST_BITS   64
`define MEM_BURST_BEATS  4   // beats per line

// core side
`define MEM_ADDR_BITS    32
`define MEM_WORD_BITS    32

`endif

// File: design/cache_types_pkg.sv
`include "mem_config.svh"

package cache_types_pkg;

    typedef logic [`MEM_LINE_BITS-1:0]   cacheline_t;
    typedef logic [`MEM_LINE_BITS/8-1:0] line_mask_t;  // one bit per line byte
    typedef logic [`MEM_BURST_BITS-1:0]  beat_t;

    // line port between caches, arbiter and burst adaptor
    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0] addr;  // line aligned
        logic                      read;
        logic                      write;
        cacheline_t                wdata;
    } line_req_t;

    typedef struct packed {
        logic       resp;
        cacheline_t rdata;
    } line_rsp_t;

    // burst memory port
    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic                      read;
        logic                      write;
        beat_t                     wdata;
    } burst_req_t;

    typedef struct packed {
        logic  resp;   // one pulse per beat
        beat_t rdata;
    } burst_rsp_t;

endpackage

// File: design/cpu_port_pkg.sv
`include "mem_config.svh"

package cpu_port_pkg;

    // core request, held until resp
    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0]   addr;
        logic                        read;
        logic                        write;
        logic [`MEM_WORD_BITS/8-1:0] wmask;
        logic [`MEM_WORD_BITS-1:0]   wdata;
    } word_req_t;

    typedef struct packed {
        logic                      resp;
        logic [`MEM_WORD_BITS-1:0] rdata;  // valid with resp
    } word_rsp_t;

endpackage

// File: design/word_line_adapter.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module word_line_adapter (
    input  cpu_port_pkg::word_req_t     word_i,
    input  cache_types_pkg::cacheline_t line_rdata_i,
    output logic [`MEM_WORD_BITS-1:0]   word_rdata_o,
    output cache_types_pkg::cacheline_t line_wdata_o,
    output cache_types_pkg::line_mask_t line_mask_o
);

    localparam int WORDS          = `MEM_LINE_BITS / `MEM_WORD_BITS;
    localparam int SEL_BITS       = $clog2(WORDS);
    localparam int BYTES_PER_WORD = `MEM_WORD_BITS / 8;
    localparam int BYTE_SEL_BITS  = $clog2(BYTES_PER_WORD);

    logic [SEL_BITS-1:0] word_sel;  // word slot inside the line

    assign word_sel = word_i.addr[BYTE_SEL_BITS +: SEL_BITS];

    // read path, pick the addressed word
    assign word_rdata_o = line_rdata_i[word_sel*`MEM_WORD_BITS +: `MEM_WORD_BITS];

    // write data goes to every slot, the mask decides which bytes land
    assign line_wdata_o = {WORDS{word_i.wdata}};

    // shift the 4-bit mask up to the addressed word
    assign line_mask_o = cache_types_pkg::line_mask_t'(word_i.wmask)
                         << (word_sel * BYTES_PER_WORD);

endmodule

// File: design/line_cache.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module line_cache (
    input  logic                         clk,
    input  logic                         rst_i,
    input  cache_types_pkg::line_req_t   core_req_i,
    input  cache_types_pkg::line_mask_t  core_mask_i,
    output cache_types_pkg::line_rsp_t   core_rsp_o,
    output cache_types_pkg::line_req_t   mem_req_o,
    input  cache_types_pkg::line_rsp_t   mem_rsp_i,
    output logic                         hit_o,
    output logic                         miss_o
);

    localparam int SETS     = `MEM_CACHE_SETS;
    localparam int SET_BITS = $clog2(SETS);
    localparam int OFF_BITS = $clog2(`MEM_LINE_BITS / 8);
    localparam int TAG_BITS = `MEM_ADDR_BITS - SET_BITS - OFF_BITS;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t state_q;

    logic [TAG_BITS-1:0]         tag_q  [SETS];
    cache_types_pkg::cacheline_t data_q [SETS];
    logic [SETS-1:0]             valid_q;
    logic [SETS-1:0]             dirty_q;

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] req_tag;
    logic                hit;
    logic                victim_dirty;

    // byte merge of write data into a line
    function automatic cache_types_pkg::cacheline_t merge_line(
        input cache_types_pkg::cacheline_t old_line,
        input cache_types_pkg::cacheline_t new_line,
        input cache_types_pkg::line_mask_t mask
    );
        cache_types_pkg::cacheline_t merged;
        merged = old_line;
        for (int b = 0; b < $bits(mask); b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = new_line[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign set_idx      = core_req_i.addr[OFF_BITS +: SET_BITS];
    assign req_tag      = core_req_i.addr[`MEM_ADDR_BITS-1 -: TAG_BITS];
    assign hit          = valid_q[set_idx] && (tag_q[set_idx] == req_tag);
    assign victim_dirty = valid_q[set_idx] && dirty_q[set_idx];

    // events only in the lookup cycle
    assign hit_o  = (state_q == LOOKUP) && hit;
    assign miss_o = (state_q == LOOKUP) && !hit;

    assign core_rsp_o.resp  = (state_q == RESPOND);
    assign core_rsp_o.rdata = data_q[set_idx];

    always_comb begin
        mem_req_o.read  = (state_q == FILL);
        mem_req_o.write = (state_q == WRITEBACK);
        mem_req_o.wdata = data_q[set_idx];
        if (state_q == WRITEBACK) begin
            mem_req_o.addr = {tag_q[set_idx], set_idx, {OFF_BITS{1'b0}}};  // victim line
        end else begin
            mem_req_o.addr = {req_tag, set_idx, {OFF_BITS{1'b0}}};
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (core_req_i.read || core_req_i.write) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        if (core_req_i.write) begin
                            dirty_q[set_idx] <= 1'b1;
                        end
                        state_q <= RESPOND;
                    end else if (victim_dirty) begin
                        state_q <= WRITEBACK;
                    end else begin
                        state_q <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (mem_rsp_i.resp) begin
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (mem_rsp_i.resp) begin
                        valid_q[set_idx] <= 1'b1;
                        dirty_q[set_idx] <= core_req_i.write;  // write miss lands dirty
                        state_q          <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && hit && core_req_i.write) begin
            data_q[set_idx] <= merge_line(data_q[set_idx], core_req_i.wdata, core_mask_i);
        end else if (state_q == FILL && mem_rsp_i.resp) begin
            tag_q[set_idx] <= req_tag;
            if (core_req_i.write) begin
                data_q[set_idx] <= merge_line(mem_rsp_i.rdata, core_req_i.wdata, core_mask_i);
            end else begin
                data_q[set_idx] <= mem_rsp_i.rdata;
            end
        end
    end

endmodule

// File: design/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter (
    input  logic                       clk,
    input  logic                       rst_i,
    input  cache_types_pkg::line_req_t icache_req_i,
    input  cache_types_pkg::line_req_t dcache_req_i,
    output cache_types_pkg::line_rsp_t icache_rsp_o,
    output cache_types_pkg::line_rsp_t dcache_rsp_o,
    output cache_types_pkg::line_req_t mem_req_o,
    input  cache_types_pkg::line_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_I,
        OWN_D
    } owner_t;

    owner_t owner_q;  // held until the owner's resp
    owner_t sel;

    logic i_want;
    logic d_want;

    assign i_want = icache_req_i.read || icache_req_i.write;
    assign d_want = dcache_req_i.read || dcache_req_i.write;

    // grant is combinational while idle, dcache first
    always_comb begin
        if (owner_q != OWN_NONE) begin
            sel = owner_q;
        end else if (d_want) begin
            sel = OWN_D;
        end else if (i_want) begin
            sel = OWN_I;
        end else begin
            sel = OWN_NONE;
        end
    end

    always_comb begin
        case (sel)
            OWN_D:   mem_req_o = dcache_req_i;
            OWN_I:   mem_req_o = icache_req_i;
            default: mem_req_o = '0;
        endcase
    end

    // data fans out, resp only to the owner
    assign icache_rsp_o.rdata = mem_rsp_i.rdata;
    assign icache_rsp_o.resp  = mem_rsp_i.resp && (sel == OWN_I);
    assign dcache_rsp_o.rdata = mem_rsp_i.rdata;
    assign dcache_rsp_o.resp  = mem_rsp_i.resp && (sel == OWN_D);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            owner_q <= OWN_NONE;
        end else if (mem_rsp_i.resp) begin
            owner_q <= OWN_NONE;  // transfer done, release
        end else begin
            owner_q <= sel;
        end
    end

endmodule

// File: design/burst_adaptor.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module burst_adaptor (
    input  logic                        clk,
    input  logic                        rst_i,
    input  cache_types_pkg::line_req_t  line_req_i,
    output cache_types_pkg::line_rsp_t  line_rsp_o,
    output cache_types_pkg::burst_req_t burst_req_o,
    input  cache_types_pkg::burst_rsp_t burst_rsp_i
);

    localparam int BEATS     = `MEM_BURST_BEATS;
    localparam int BEAT_BITS = `MEM_BURST_BITS;
    localparam int CNT_BITS  = $clog2(BEATS);

    typedef enum logic [1:0] {
        B_IDLE,
        B_READ,
        B_WRITE,
        B_DONE
    } bstate_t;

    bstate_t                     state_q;
    logic [CNT_BITS-1:0]         beat_q;
    logic [`MEM_ADDR_BITS-1:0]   addr_q;
    cache_types_pkg::cacheline_t buf_q;   // shifts one beat per resp

    logic last_beat;

    assign last_beat = burst_rsp_i.resp && (beat_q == CNT_BITS'(BEATS - 1));

    assign burst_req_o.addr  = addr_q;
    assign burst_req_o.read  = (state_q == B_READ);
    assign burst_req_o.write = (state_q == B_WRITE);
    assign burst_req_o.wdata = buf_q[BEAT_BITS-1:0];  // lowest beat goes first

    assign line_rsp_o.resp  = (state_q == B_DONE);
    assign line_rsp_o.rdata = buf_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= B_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                B_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.read) begin
                        state_q <= B_READ;
                    end else if (line_req_i.write) begin
                        state_q <= B_WRITE;
                    end
                end
                B_READ, B_WRITE: begin
                    if (burst_rsp_i.resp) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= B_DONE;
                    end
                end
                B_DONE:  state_q <= B_IDLE;
                default: state_q <= B_IDLE;
            endcase
        end
    end

    // address capture and line shift buffer
    always_ff @(posedge clk) begin
        if (state_q == B_IDLE) begin
            addr_q <= line_req_i.addr;
            buf_q  <= line_req_i.wdata;
        end else if (state_q == B_READ && burst_rsp_i.resp) begin
            buf_q <= {burst_rsp_i.rdata, buf_q[`MEM_LINE_BITS-1:BEAT_BITS]};
        end else if (state_q == B_WRITE && burst_rsp_i.resp) begin
            buf_q <= buf_q >> BEAT_BITS;
        end
    end

endmodule

// File: design/mem_hier_top.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_hier_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  cpu_port_pkg::word_req_t     imem_req_i,
    input  cpu_port_pkg::word_req_t     dmem_req_i,
    output cpu_port_pkg::word_rsp_t     imem_rsp_o,
    output cpu_port_pkg::word_rsp_t     dmem_rsp_o,
    output cache_types_pkg::burst_req_t bmem_req_o,
    input  cache_types_pkg::burst_rsp_t bmem_rsp_i,
    output logic                        i_hit_o,
    output logic                        i_miss_o,
    output logic                        d_hit_o,
    output logic                        d_miss_o
);

    localparam int OFF_BITS = $clog2(`MEM_LINE_BITS / 8);

    logic [`MEM_WORD_BITS-1:0]   i_word_rdata;
    logic [`MEM_WORD_BITS-1:0]   d_word_rdata;
    cache_types_pkg::cacheline_t d_line_wdata;
    cache_types_pkg::line_mask_t d_line_mask;

    cache_types_pkg::line_req_t i_core_req, d_core_req;    // core side of the caches
    cache_types_pkg::line_rsp_t i_core_rsp, d_core_rsp;
    cache_types_pkg::line_req_t i_mem_req, d_mem_req;      // caches to arbiter
    cache_types_pkg::line_rsp_t i_mem_rsp, d_mem_rsp;
    cache_types_pkg::line_req_t arb_req;                   // arbiter to adaptor
    cache_types_pkg::line_rsp_t arb_rsp;

    // line aligned requests, icache is read only
    assign i_core_req = '{addr:  {imem_req_i.addr[`MEM_ADDR_BITS-1:OFF_BITS], {OFF_BITS{1'b0}}},
                          read:  imem_req_i.read,
                          write: 1'b0,
                          wdata: '0};
    assign d_core_req = '{addr:  {dmem_req_i.addr[`MEM_ADDR_BITS-1:OFF_BITS], {OFF_BITS{1'b0}}},
                          read:  dmem_req_i.read,
                          write: dmem_req_i.write,
                          wdata: d_line_wdata};

    assign imem_rsp_o = '{resp: i_core_rsp.resp, rdata: i_word_rdata};
    assign dmem_rsp_o = '{resp: d_core_rsp.resp, rdata: d_word_rdata};

    word_line_adapter i_imem_adapter (
        .word_i(imem_req_i), .line_rdata_i(i_core_rsp.rdata),
        .word_rdata_o(i_word_rdata), .line_wdata_o(), .line_mask_o()
    );

    word_line_adapter i_dmem_adapter (
        .word_i(dmem_req_i), .line_rdata_i(d_core_rsp.rdata),
        .word_rdata_o(d_word_rdata), .line_wdata_o(d_line_wdata), .line_mask_o(d_line_mask)
    );

    line_cache i_icache (
        .clk(clk), .rst_i(rst_i),
        .core_req_i(i_core_req), .core_mask_i('0), .core_rsp_o(i_core_rsp),
        .mem_req_o(i_mem_req), .mem_rsp_i(i_mem_rsp),
        .hit_o(i_hit_o), .miss_o(i_miss_o)
    );

    line_cache i_dcache (
        .clk(clk), .rst_i(rst_i),
        .core_req_i(d_core_req), .core_mask_i(d_line_mask), .core_rsp_o(d_core_rsp),
        .mem_req_o(d_mem_req), .mem_rsp_i(d_mem_rsp),
        .hit_o(d_hit_o), .miss_o(d_miss_o)
    );

    line_arbiter i_arbiter (
        .clk(clk), .rst_i(rst_i),
        .icache_req_i(i_mem_req), .dcache_req_i(d_mem_req),
        .icache_rsp_o(i_mem_rsp), .dcache_rsp_o(d_mem_rsp),
        .mem_req_o(arb_req), .mem_rsp_i(arb_rsp)
    );

    burst_adaptor i_burst_adaptor (
        .clk(clk), .rst_i(rst_i),
        .line_req_i(arb_req), .line_rsp_o(arb_rsp),
        .burst_req_o(bmem_req_o), .burst_rsp_i(bmem_rsp_i)
    );

endmodule

// File: bench/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                        clk,
    input  logic                        rst_i,
    input  cache_types_pkg::burst_req_t req_i,
    output cache_types_pkg::burst_rsp_t rsp_o
);

    logic [31:0] mem [int unsigned];  // only written words are stored
    logic [2:0]  beat;
    logic        started;             // gap cycle before the first beat

    function automatic logic [31:0] load_word(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a_0000);
    endfunction

    always @(posedge clk) begin
        logic [31:0] a;
        if (rst_i) begin
            rsp_o   <= '0;
            beat    <= 3'd0;
            started <= 1'b0;
        end else begin
            rsp_o.resp <= 1'b0;
            // write data of the beat that is being answered now
            if (rsp_o.resp && req_i.write) begin
                a = req_i.addr + {26'd0, beat - 3'd1, 3'b000};
                mem[a]         = req_i.wdata[31:0];
                mem[a + 32'd4] = req_i.wdata[63:32];
            end
            if (!(req_i.read || req_i.write)) begin
                beat    <= 3'd0;
                started <= 1'b0;
            end else if (!started) begin
                started <= 1'b1;
            end else if (beat < 3'd4) begin
                a = req_i.addr + {26'd0, beat, 3'b000};
                rsp_o.resp  <= 1'b1;
                rsp_o.rdata <= {load_word(a + 32'd4), load_word(a)};  // lowest word first
                beat        <= beat + 3'd1;
            end
        end
    end

endmodule

// File: bench/mem_hier_props.sv
`timescale 1ns/1ps

module mem_hier_props (
    input logic                        clk,
    input logic                        rst_i,
    input cpu_port_pkg::word_req_t     imem_req_i,
    input cpu_port_pkg::word_req_t     dmem_req_i,
    input cpu_port_pkg::word_rsp_t     imem_rsp_o,
    input cpu_port_pkg::word_rsp_t     dmem_rsp_o,
    input cache_types_pkg::burst_req_t bmem_req_o
);

    bit prop_failed = 1'b0;  // watched by the testbench

    // core requests hold until resp
    a_d_stable: assert property (@(posedge clk) disable iff (rst_i)
        (dmem_req_i.read || dmem_req_i.write) && !dmem_rsp_o.resp |=> $stable(dmem_req_i))
        else begin prop_failed = 1'b1; $error("dmem request changed before resp"); end
    a_i_stable: assert property (@(posedge clk) disable iff (rst_i)
        (imem_req_i.read || imem_req_i.write) && !imem_rsp_o.resp |=> $stable(imem_req_i))
        else begin prop_failed = 1'b1; $error("imem request changed before resp"); end

    a_d_resp: assert property (@(posedge clk) disable iff (rst_i)
        dmem_rsp_o.resp |-> (dmem_req_i.read || dmem_req_i.write))
        else begin prop_failed = 1'b1; $error("dmem resp without a request"); end
    a_i_resp: assert property (@(posedge clk) disable iff (rst_i)
        imem_rsp_o.resp |-> (imem_req_i.read || imem_req_i.write))
        else begin prop_failed = 1'b1; $error("imem resp without a request"); end

    a_bmem_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(bmem_req_o.read && bmem_req_o.write))
        else begin prop_failed = 1'b1; $error("bmem read and write both high"); end

endmodule

bind mem_hier_top mem_hier_props i_props (
    .clk(clk), .rst_i(rst_i),
    .imem_req_i(imem_req_i), .dmem_req_i(dmem_req_i),
    .imem_rsp_o(imem_rsp_o), .dmem_rsp_o(dmem_rsp_o),
    .bmem_req_o(bmem_req_o)
);

// File: bench/mem_hier_tb.sv
`timescale 1ns/1ps

module mem_hier_tb;

    localparam int MAX_CYCLES = 20000;

    logic clk = 1'b0;
    logic rst_i;
    cpu_port_pkg::word_req_t     ireq, dreq;
    cpu_port_pkg::word_rsp_t     irsp, drsp;
    cache_types_pkg::burst_req_t breq;
    cache_types_pkg::burst_rsp_t brsp;
    logic i_hit, i_miss, d_hit, d_miss;

    logic [31:0] refm [int unsigned];  // absent words read back as the pattern
    logic [31:0] rng_state;
    int          cycles = 0;

    mem_hier_top i_dut (
        .clk(clk), .rst_i(rst_i), .imem_req_i(ireq), .dmem_req_i(dreq),
        .imem_rsp_o(irsp), .dmem_rsp_o(drsp), .bmem_req_o(breq), .bmem_rsp_i(brsp),
        .i_hit_o(i_hit), .i_miss_o(i_miss), .d_hit_o(d_hit), .d_miss_o(d_miss)
    );

    burst_mem_model i_mem (.clk(clk), .rst_i(rst_i), .req_i(breq), .rsp_o(brsp));

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles", cycles);
            abort_run("simulation timed out");
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_props.prop_failed) abort_run("a bus assertion failed");
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return refm.exists(a) ? refm[a] : (a ^ 32'h5a5a_0000);
    endfunction

    task automatic check_word(input cpu_port_pkg::word_rsp_t rsp, input logic [31:0] exp,
                              input string what);
        if (rsp.rdata !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, what, exp, rsp.rdata);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_event(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %b got %b", $time, what, exp, got);
            abort_run("event mismatch");
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t: %s expected %0d cycles got %0d", $time, what, exp, got);
            abort_run("latency mismatch");
        end
    endtask

    // one request held on one port until resp
    task automatic access(input bit on_i, input logic [31:0] a, input bit wr,
                          input logic [3:0] mask, input logic [31:0] wd,
                          output cpu_port_pkg::word_rsp_t rsp, output bit hit, output bit miss,
                          output int lat);
        cpu_port_pkg::word_req_t req;
        req = '{addr: a, read: !wr, write: wr, wmask: mask, wdata: wd};
        hit = 1'b0;
        miss = 1'b0;
        lat = 0;
        @(posedge clk);
        if (on_i) begin
            ireq <= req;
        end else begin
            dreq <= req;
        end
        forever begin
            @(negedge clk);
            hit |= on_i ? i_hit : d_hit;
            miss |= on_i ? i_miss : d_miss;
            rsp = on_i ? irsp : drsp;
            if (rsp.resp) break;
            lat++;
        end
        @(posedge clk);
        if (on_i) begin
            ireq <= '0;
        end else begin
            dreq <= '0;
        end
    endtask

    task automatic read_check(input bit on_i, input logic [31:0] a, input bit chk_ev,
                              input bit exp_hit, output int lat);
        cpu_port_pkg::word_rsp_t rsp;
        bit hit, miss;
        access(on_i, a, 1'b0, 4'h0, 32'h0, rsp, hit, miss, lat);
        check_word(rsp, ref_word(a), on_i ? "imem read" : "dmem read");
        if (chk_ev) begin
            check_event(on_i ? "i_hit" : "d_hit", hit, exp_hit);
            check_event(on_i ? "i_miss" : "d_miss", miss, !exp_hit);
        end
    endtask

    task automatic write_word(input logic [31:0] a, input logic [3:0] mask,
                              input logic [31:0] wd);
        cpu_port_pkg::word_rsp_t rsp;
        bit hit, miss;
        int lat;
        logic [31:0] w;
        access(1'b0, a, 1'b1, mask, wd, rsp, hit, miss, lat);
        w = ref_word(a);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[8*b +: 8] = wd[8*b +: 8];
        end
        refm[a] = w;
    endtask

    task automatic cold_read_then_hit();
        int lat;
        read_check(1'b0, 32'h0000_1004, 1'b1, 1'b0, lat);
        read_check(1'b0, 32'h0000_1008, 1'b1, 1'b1, lat);
        check_latency("dmem hit latency", lat, 2);
    endtask

    task automatic ifetch_new_line();
        int lat;
        read_check(1'b1, 32'h0000_2000, 1'b1, 1'b0, lat);
        read_check(1'b1, 32'h0000_2010, 1'b1, 1'b1, lat);
    endtask

    task automatic masked_write_readback();
        int lat;
        write_word(32'h0000_1008, 4'b0101, next_rand());
        read_check(1'b0, 32'h0000_1008, 1'b1, 1'b1, lat);
    endtask

    task automatic dirty_eviction();
        int lat;
        write_word(32'h0000_1004, 4'hf, next_rand());
        read_check(1'b0, 32'h0000_3004, 1'b1, 1'b0, lat);  // same set with a dirty victim
        read_check(1'b0, 32'h0000_1004, 1'b1, 1'b0, lat);
    endtask

    task automatic port_contention();
        bit idone, ddone;
        idone = 1'b0;
        ddone = 1'b0;
        @(posedge clk);
        ireq <= '{addr: 32'h0000_4008, read: 1'b1, write: 1'b0, wmask: 4'h0, wdata: 32'h0};
        dreq <= '{addr: 32'h0000_5014, read: 1'b1, write: 1'b0, wmask: 4'h0, wdata: 32'h0};
        while (!(idone && ddone)) begin
            @(negedge clk);
            if (irsp.resp) begin
                check_word(irsp, ref_word(32'h0000_4008), "imem read under contention");
                idone = 1'b1;
            end
            if (drsp.resp) begin
                check_word(drsp, ref_word(32'h0000_5014), "dmem read under contention");
                ddone = 1'b1;
            end
            @(posedge clk);
            if (idone) ireq <= '0;
            if (ddone) dreq <= '0;
        end
    endtask

    task automatic random_data_traffic();
        logic [31:0] r, a;
        int lat;
        for (int n = 0; n < 80; n++) begin
            r = next_rand();
            a = 32'h0000_8000 | {20'd0, r[11:2], 2'b00};  // 4 KB window forces many evictions
            if (r[31]) write_word(a, r[27:24], next_rand());
            else read_check(1'b0, a, 1'b0, 1'b0, lat);
        end
    endtask

    initial begin
        ireq = '0;
        dreq = '0;
        rst_i = 1'b1;
        rng_state = 32'h372b_a21e;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_event("dmem resp after reset", drsp.resp, 1'b0);
        check_event("imem resp after reset", irsp.resp, 1'b0);
        check_event("bmem read after reset", breq.read, 1'b0);
        check_event("bmem write after reset", breq.write, 1'b0);
        check_event("i_hit after reset", i_hit, 1'b0);
        check_event("i_miss after reset", i_miss, 1'b0);
        check_event("d_hit after reset", d_hit, 1'b0);
        check_event("d_miss after reset", d_miss, 1'b0);
        cold_read_then_hit();
        ifetch_new_line();
        masked_write_readback();
        dirty_eviction();
        port_contention();
        random_data_traffic();
        @(posedge clk);
        if (i_dut.i_props.prop_failed) begin
            abort_run("a bus assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+design
design/cache_types_pkg.sv
design/cpu_port_pkg.sv
design/word_line_adapter.sv
design/line_cache.sv
design/line_arbiter.sv
design/burst_adaptor.sv
design/mem_hier_top.sv
bench/burst_mem_model.sv
bench/mem_hier_props.sv
bench/mem_hier_tb.sv

// File: Makefile
SIM_TOP = mem_hier_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(SIM_TOP) -o V$(SIM_TOP)

run: build
	./obj_dir/V$(SIM_TOP) > run.log 2>&1; cat run.log
	grep -q "Done: no errors" run.log

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(SIM_TOP)
	verilator --lint-only -f filelist.f --top-module mem_hier_top

clean:
	rm -rf obj_dir run.log
